//--- hdl/lspPkg.sv
`default_nettype none

package lspPkg;

	//////////////////////////////////////////////////
	// Memory geometry
	//////////////////////////////////////////////////

	// Scratch memory address width
	localparam int addrWidth = 12;

	// One scratch word
	localparam int dataWidth = 32;

	//////////////////////////////////////////////////
	// LSP vector geometry
	//////////////////////////////////////////////////

	// M coefficients per LSP vector
	localparam int lspOrder = 10;

	// Bits for a coefficient index 0..M-1
	localparam int coeffWidth = $clog2(lspOrder);

	// Stored previous frames of the MA predictor
	localparam int maNpDefault = 4;

	//////////////////////////////////////////////////
	// Update engine states
	//////////////////////////////////////////////////

	typedef enum logic [2:0]
	{
		// Waiting for start
		stIdle       = 3'd0,
		// Present history source address
		stShiftRead  = 3'd1,
		// Write older word into newer slot
		stShiftWrite = 3'd2,
		// Present current vector address
		stLoadRead   = 3'd3,
		// Write current vector into slot 0
		stLoadWrite  = 3'd4,
		// One cycle before done pulse
		stDone       = 3'd5
	} updateState_t;

endpackage

`default_nettype wire

//--- hdl/scratchMemoryController.sv
`timescale 1ns/10ps
`default_nettype none

module scratchMemoryController
#(
	parameter int memDepth = 4096
)
(
	input  logic                          clk,
	input  logic                          updateMuxSel,
	// Engine side
	input  logic [lspPkg::addrWidth-1:0]  memReadAddr,
	input  logic [lspPkg::addrWidth-1:0]  memWriteAddr,
	input  logic [lspPkg::dataWidth-1:0]  memOut,
	input  logic                          memWriteEn,
	// Test side
	input  logic [lspPkg::addrWidth-1:0]  testReadAddr,
	input  logic [lspPkg::addrWidth-1:0]  testWriteAddr,
	input  logic [lspPkg::dataWidth-1:0]  testMemOut,
	input  logic                          testMemWriteEn,
	// Registered read data
	output logic [lspPkg::dataWidth-1:0]  memIn
);

	import lspPkg::*;

	//////////////////////////////////////////////////
	// Port selection
	//////////////////////////////////////////////////

	logic [addrWidth-1:0] readAddr;
	logic [addrWidth-1:0] writeAddr;
	logic [dataWidth-1:0] writeData;
	logic                 writeEn;

	// Test port owns the memory while select is high
	always_comb
	begin
		if (updateMuxSel)
		begin
			readAddr  = testReadAddr;
			writeAddr = testWriteAddr;
			writeData = testMemOut;
			writeEn   = testMemWriteEn;
		end
		else
		begin
			readAddr  = memReadAddr;
			writeAddr = memWriteAddr;
			writeData = memOut;
			writeEn   = memWriteEn;
		end
	end

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	// Simple dual port array
	logic [dataWidth-1:0] mem [memDepth];

	// Write port
	always_ff @(posedge clk)
	begin
		if (writeEn)
		begin
			mem[writeAddr] <= writeData;
		end
	end

	// Read port, one cycle latency
	// Same-address collision returns the old word
	always_ff @(posedge clk)
	begin
		memIn <= mem[readAddr];
	end

endmodule

`default_nettype wire

//--- hdl/lspPrevUpdateFsm.sv
`timescale 1ns/10ps
`default_nettype none

module lspPrevUpdateFsm
#(
	parameter int maNp = lspPkg::maNpDefault
)
(
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          start,
	// Read data from scratch memory
	input  logic [lspPkg::dataWidth-1:0]  memIn,
	// Base of current LSP vector
	input  logic [lspPkg::addrWidth-1:0]  lspEleAddr,
	// Base of previous-frame history
	input  logic [lspPkg::addrWidth-1:0]  freqPrevAddr,
	output logic [lspPkg::addrWidth-1:0]  memReadAddr,
	output logic [lspPkg::addrWidth-1:0]  memWriteAddr,
	output logic [lspPkg::dataWidth-1:0]  memOut,
	output logic                          memWriteEn,
	output logic                          done
);

	import lspPkg::*;

	//////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////

	// Slot counter holds k in maNp-1 .. 1
	localparam int slotWidth = (maNp > 1) ? $clog2(maNp) : 1;

	// History exists only with two or more slots
	localparam bit hasShift = (maNp > 1);

	// Offset of slot k-1 for the first k
	localparam logic [addrWidth-1:0] firstSlotBase =
		(maNp > 1) ? addrWidth'((maNp - 2) * lspOrder) : '0;

	// Distance between neighbouring slots
	localparam logic [addrWidth-1:0] vecStride = addrWidth'(lspOrder);

	localparam logic [coeffWidth-1:0] lastCoeff = coeffWidth'(lspOrder - 1);
	localparam logic [slotWidth-1:0]  firstSlot = slotWidth'(maNp - 1);
	localparam logic [slotWidth-1:0]  lastSlot  = slotWidth'(1);

	//////////////////////////////////////////////////
	// State and counters
	//////////////////////////////////////////////////

	updateState_t state;
	updateState_t stateNext;

	// Destination slot k of the shift phase
	logic [slotWidth-1:0]  slot;
	// Coefficient i within a vector
	logic [coeffWidth-1:0] coeff;
	// Running offset (k-1)*M, no multiplier
	logic [addrWidth-1:0]  slotBase;
	logic                  doneReg;

	// End of vector flag
	logic                  coeffLast;

	assign coeffLast = (coeff == lastCoeff);

	// Next state
	always_comb
	begin
		stateNext = state;
		unique case (state)
			stIdle:
			begin
				// Start is only honoured here
				if (start)
				begin
					stateNext = hasShift ? stShiftRead : stLoadRead;
				end
			end
			stShiftRead:
			begin
				stateNext = stShiftWrite;
			end
			stShiftWrite:
			begin
				if (coeffLast && (slot == lastSlot))
				begin
					stateNext = stLoadRead;
				end
				else
				begin
					stateNext = stShiftRead;
				end
			end
			stLoadRead:
			begin
				stateNext = stLoadWrite;
			end
			stLoadWrite:
			begin
				stateNext = coeffLast ? stDone : stLoadRead;
			end
			stDone:
			begin
				stateNext = stIdle;
			end
			default:
			begin
				stateNext = stIdle;
			end
		endcase
	end

	// State register
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
		end
		else
		begin
			state <= stateNext;
		end
	end

	// Slot and coefficient walk
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			slot     <= '0;
			coeff    <= '0;
			slotBase <= '0;
		end
		else
		begin
			unique case (state)
				stIdle:
				begin
					slot     <= firstSlot;
					coeff    <= '0;
					slotBase <= firstSlotBase;
				end
				stShiftWrite:
				begin
					if (coeffLast)
					begin
						// Step one slot towards slot 0
						coeff    <= '0;
						slot     <= slot - 1'b1;
						slotBase <= slotBase - vecStride;
					end
					else
					begin
						coeff <= coeff + 1'b1;
					end
				end
				stLoadWrite:
				begin
					coeff <= coeffLast ? '0 : coeff + 1'b1;
				end
				default:
				begin
					// Counters hold in read and done cycles
					slot <= slot;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Address generation
	//////////////////////////////////////////////////

	logic [addrWidth-1:0] coeffExt;
	logic [addrWidth-1:0] shiftSrcAddr;
	logic [addrWidth-1:0] shiftDstAddr;
	logic [addrWidth-1:0] loadSrcAddr;
	logic [addrWidth-1:0] loadDstAddr;

	assign coeffExt = {{(addrWidth - coeffWidth){1'b0}}, coeff};

	// Slot k-1 word i
	assign shiftSrcAddr = freqPrevAddr + slotBase + coeffExt;
	// Slot k word i, one vector further on
	assign shiftDstAddr = shiftSrcAddr + vecStride;
	// Current vector word i
	assign loadSrcAddr  = lspEleAddr + coeffExt;
	// Slot 0 word i
	assign loadDstAddr  = freqPrevAddr + coeffExt;

	assign memReadAddr  = (state == stLoadRead) ? loadSrcAddr : shiftSrcAddr;
	assign memWriteAddr = (state == stLoadWrite) ? loadDstAddr : shiftDstAddr;

	// Word captured by the memory read register
	assign memOut     = memIn;
	assign memWriteEn = (state == stShiftWrite) || (state == stLoadWrite);

	//////////////////////////////////////////////////
	// Completion
	//////////////////////////////////////////////////

	// Pulse one cycle after stDone
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			doneReg <= 1'b0;
		end
		else
		begin
			doneReg <= (state == stDone);
		end
	end

	assign done = doneReg;

endmodule

`default_nettype wire

//--- hdl/lspPrevUpdatePipe.sv
`timescale 1ns/10ps
`default_nettype none

module lspPrevUpdatePipe
#(
	parameter int maNp = lspPkg::maNpDefault
)
(
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          start,
	// High hands the memory to the test port
	input  logic                          updateMuxSel,
	input  logic [lspPkg::addrWidth-1:0]  testReadAddr,
	input  logic [lspPkg::addrWidth-1:0]  testWriteAddr,
	input  logic [lspPkg::dataWidth-1:0]  testMemOut,
	input  logic                          testMemWriteEn,
	input  logic [lspPkg::addrWidth-1:0]  lspEleAddr,
	input  logic [lspPkg::addrWidth-1:0]  freqPrevAddr,
	output logic [lspPkg::dataWidth-1:0]  memIn,
	output logic                          done
);

	import lspPkg::*;

	// Full address space of the scratch memory
	localparam int memDepth = 1 << addrWidth;

	//////////////////////////////////////////////////
	// Engine to memory
	//////////////////////////////////////////////////

	logic [addrWidth-1:0] memReadAddr;
	logic [addrWidth-1:0] memWriteAddr;
	logic [dataWidth-1:0] memOut;
	logic                 memWriteEn;

	// Copy engine
	lspPrevUpdateFsm #(
		.maNp         (maNp)
	) fsm (
		.clk          (clk),
		.arstN        (arstN),
		.start        (start),
		.memIn        (memIn),
		.lspEleAddr   (lspEleAddr),
		.freqPrevAddr (freqPrevAddr),
		.memReadAddr  (memReadAddr),
		.memWriteAddr (memWriteAddr),
		.memOut       (memOut),
		.memWriteEn   (memWriteEn),
		.done         (done)
	);

	// Shared scratch memory
	// Read data goes both to the engine and out
	scratchMemoryController #(
		.memDepth       (memDepth)
	) testMem (
		.clk            (clk),
		.updateMuxSel   (updateMuxSel),
		.memReadAddr    (memReadAddr),
		.memWriteAddr   (memWriteAddr),
		.memOut         (memOut),
		.memWriteEn     (memWriteEn),
		.testReadAddr   (testReadAddr),
		.testWriteAddr  (testWriteAddr),
		.testMemOut     (testMemOut),
		.testMemWriteEn (testMemWriteEn),
		.memIn          (memIn)
	);

endmodule

`default_nettype wire

//--- verif/lspPrevUpdateTb.sv
`timescale 1ns/10ps
`default_nettype none

module lspPrevUpdateTb;

	import lspPkg::*;

	localparam int maNp = maNpDefault;
	// Words in the whole history
	localparam int histLen = maNp * lspOrder;
	// Two cycles per word plus margin
	localparam int doneTimeout = 4 * histLen + 20;
	localparam int addrMax = (1 << addrWidth) - 1;

	logic                 clk;
	logic                 arstN;
	logic                 start;
	logic                 updateMuxSel;
	logic [addrWidth-1:0] testReadAddr;
	logic [addrWidth-1:0] testWriteAddr;
	logic [dataWidth-1:0] testMemOut;
	logic                 testMemWriteEn;
	logic [addrWidth-1:0] lspEleAddr;
	logic [addrWidth-1:0] freqPrevAddr;
	logic [dataWidth-1:0] memIn;
	logic                 done;

	// Reference copy of the scratch memory
	logic [dataWidth-1:0] modelMem [int];

	int          errorCount = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;
	int          doneCount = 0;

	lspPrevUpdatePipe #(
		.maNp           (maNp)
	) lspPrevUpdatePipe_inst (
		.clk            (clk),
		.arstN          (arstN),
		.start          (start),
		.updateMuxSel   (updateMuxSel),
		.testReadAddr   (testReadAddr),
		.testWriteAddr  (testWriteAddr),
		.testMemOut     (testMemOut),
		.testMemWriteEn (testMemWriteEn),
		.lspEleAddr     (lspEleAddr),
		.freqPrevAddr   (freqPrevAddr),
		.memIn          (memIn),
		.done           (done)
	);

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	// Done pulses sampled mid cycle
	always @(negedge clk)
	begin
		if (done === 1'b1)
		begin
			doneCount = doneCount + 1;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Edge and then the drive point 1 ns later
	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkValue(input string testName, input logic [dataWidth-1:0] expected,
		input logic [dataWidth-1:0] actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED test %s expected %h actual %h", testName, expected, actual);
		end
	endtask

	task automatic applyReset();
		int n;
		arstN = 1'b0;
		for (n = 0; n < 4; n++)
		begin
			stepCycle();
		end
		arstN = 1'b1;
	endtask

	// Test port write mirrored into the model
	task automatic writeWord(input int addr, input logic [dataWidth-1:0] data);
		updateMuxSel   = 1'b1;
		testWriteAddr  = addr[addrWidth-1:0];
		testMemOut     = data;
		testMemWriteEn = 1'b1;
		stepCycle();
		testMemWriteEn = 1'b0;
		modelMem[addr] = data;
	endtask

	// One cycle read latency
	task automatic readWord(input int addr, output logic [dataWidth-1:0] data);
		updateMuxSel = 1'b1;
		testReadAddr = addr[addrWidth-1:0];
		stepCycle();
		data = memIn;
	endtask

	task automatic verifyRange(input string testName, input int base, input int len);
		logic [dataWidth-1:0] got;
		int i;
		for (i = 0; i < len; i++)
		begin
			readWord(base + i, got);
			checkValue(testName, modelMem[base + i], got);
		end
	endtask

	task automatic loadRandom(input int base, input int len);
		int i;
		for (i = 0; i < len; i++)
		begin
			writeWord(base + i, $urandom());
		end
	endtask

	// History in the lower half and current vector in the upper half
	task automatic pickBases();
		freqPrevAddr = addrWidth'($urandom_range(addrMax / 2 - histLen - 1, 16));
		lspEleAddr   = addrWidth'($urandom_range(addrMax - lspOrder, addrMax / 2 + 16));
	endtask

	// Slot k takes slot k-1 and slot 0 takes the current vector
	function automatic void applyModelUpdate(input int fp, input int le);
		int k;
		int i;
		for (k = maNp - 1; k >= 1; k--)
		begin
			for (i = 0; i < lspOrder; i++)
			begin
				modelMem[fp + k * lspOrder + i] = modelMem[fp + (k - 1) * lspOrder + i];
			end
		end
		for (i = 0; i < lspOrder; i++)
		begin
			modelMem[fp + i] = modelMem[le + i];
		end
	endfunction

	task automatic pulseStart();
		updateMuxSel = 1'b0;
		start        = 1'b1;
		stepCycle();
		start        = 1'b0;
	endtask

	task automatic waitForDone(input string testName);
		int  cycles;
		bit  seen;
		seen = 1'b0;
		for (cycles = 0; cycles < doneTimeout && !seen; cycles++)
		begin
			stepCycle();
			if (done === 1'b1)
			begin
				seen = 1'b1;
			end
		end
		if (!seen)
		begin
			errorCount++;
			$display("Timeout in test %s: done never came after start", testName);
		end
	endtask

	task automatic runUpdate(input string testName);
		pulseStart();
		waitForDone(testName);
		applyModelUpdate(freqPrevAddr, lspEleAddr);
	endtask

	task automatic finishTest(input string testName, input int errorsBefore);
		if (errorCount == errorsBefore)
		begin
			testsPassed++;
			$display("Test %s: passed", testName);
		end
		else
		begin
			testsFailed++;
			$display("Test %s: failed with %0d errors", testName, errorCount - errorsBefore);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [dataWidth-1:0] got;
		int                   addrQueue [$];
		int                   errorsBefore;
		int                   addr;
		int                   n;
		int                   resetCount;
		void'($urandom(32'hd4f7_b057));
		arstN          = 1'b0;
		start          = 1'b0;
		updateMuxSel   = 1'b1;
		testReadAddr   = '0;
		testWriteAddr  = '0;
		testMemOut     = '0;
		testMemWriteEn = 1'b0;
		lspEleAddr     = '0;
		freqPrevAddr   = '0;
		applyReset();

		// Random words through the test port
		errorsBefore = errorCount;
		for (n = 0; n < 32; n++)
		begin
			addr = $urandom_range(addrMax, 0);
			writeWord(addr, $urandom());
			addrQueue.push_back(addr);
		end
		for (n = 0; n < addrQueue.size(); n++)
		begin
			readWord(addrQueue[n], got);
			checkValue("testPort", modelMem[addrQueue[n]], got);
		end
		finishTest("testPort", errorsBefore);

		// One shift of a fresh history
		errorsBefore = errorCount;
		pickBases();
		loadRandom(freqPrevAddr, histLen);
		loadRandom(lspEleAddr, lspOrder);
		runUpdate("singleUpdate");
		verifyRange("singleUpdate", freqPrevAddr, histLen);
		finishTest("singleUpdate", errorsBefore);

		// Vectors walk through every slot and fall off the end
		errorsBefore = errorCount;
		pickBases();
		loadRandom(freqPrevAddr, histLen);
		for (n = 0; n <= maNp; n++)
		begin
			loadRandom(lspEleAddr, lspOrder);
			runUpdate("repeatedUpdate");
			verifyRange("repeatedUpdate", freqPrevAddr, histLen);
		end
		finishTest("repeatedUpdate", errorsBefore);

		// Guard words around the history and the source vector
		errorsBefore = errorCount;
		pickBases();
		writeWord(freqPrevAddr - 1, $urandom());
		writeWord(freqPrevAddr + histLen, $urandom());
		loadRandom(freqPrevAddr, histLen);
		loadRandom(lspEleAddr, lspOrder);
		runUpdate("untouchedMemory");
		verifyRange("untouchedMemory", freqPrevAddr - 1, 1);
		verifyRange("untouchedMemory", freqPrevAddr + histLen, 1);
		verifyRange("untouchedMemory", lspEleAddr, lspOrder);
		verifyRange("untouchedMemory", freqPrevAddr, histLen);
		finishTest("untouchedMemory", errorsBefore);

		// Fresh reset and a start while busy
		errorsBefore = errorCount;
		applyReset();
		resetCount = doneCount;
		for (n = 0; n < 8; n++)
		begin
			stepCycle();
			checkValue("resetStrobe", 1'b0, done);
		end
		pickBases();
		loadRandom(freqPrevAddr, histLen);
		loadRandom(lspEleAddr, lspOrder);
		checkValue("resetStrobe", resetCount, doneCount);
		pulseStart();
		for (n = 0; n < 5; n++)
		begin
			stepCycle();
		end
		// Engine is mid shift here
		pulseStart();
		waitForDone("resetStrobe");
		applyModelUpdate(freqPrevAddr, lspEleAddr);
		// A second pulse would show up in this window
		for (n = 0; n < doneTimeout; n++)
		begin
			stepCycle();
		end
		checkValue("resetStrobe", resetCount + 1, doneCount);
		verifyRange("resetStrobe", freqPrevAddr, histLen);
		verifyRange("resetStrobe", lspEleAddr, lspOrder);
		finishTest("resetStrobe", errorsBefore);

		$display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (errorCount == 0 && testsFailed == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
hdl/lspPkg.sv
hdl/scratchMemoryController.sv
hdl/lspPrevUpdateFsm.sv
hdl/lspPrevUpdatePipe.sv
verif/lspPrevUpdateTb.sv

//--- Bender.yml
package:
  name: lsp_prev_update

sources:
  # Design, in compile order
  - hdl/lspPkg.sv
  - hdl/scratchMemoryController.sv
  - hdl/lspPrevUpdateFsm.sv
  - hdl/lspPrevUpdatePipe.sv
  # Testbench
  - target: simulation
    files:
      - verif/lspPrevUpdateTb.sv
